// File: Bender.yml
package:
  name: mem_req_path

sources:
  - rtl/mem_req_pkg.sv
  - rtl/req_queue.sv
  - rtl/wb_issue.sv
  - rtl/mem_req_path.sv
  - target: test
    files:
      - test/wb_mem_model.sv
      - test/tb_mem_req_path.sv

// File: filelist.f
rtl/mem_req_pkg.sv
rtl/req_queue.sv
rtl/wb_issue.sv
rtl/mem_req_path.sv
test/wb_mem_model.sv
test/tb_mem_req_path.sv

// File: rtl/mem_req_path.sv
`timescale 1ns/100ps

module mem_req_path (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             req_valid_i,
   input  mem_req_pkg::mem_op_e             req_op_i,
   input  logic [mem_req_pkg::ADDR_W-1:0]   req_addr_i,
   input  logic [mem_req_pkg::DATA_W-1:0]   req_data_i,
   input  logic [mem_req_pkg::TAG_W-1:0]    req_tag_i,
   output logic                             req_grant_o,
   output logic                             wb_cyc_o,
   output logic                             wb_stb_o,
   output logic                             wb_we_o,
   output logic [mem_req_pkg::ADDR_W-1:0]   wb_adr_o,
   output logic [mem_req_pkg::DATA_W-1:0]   wb_dat_o,
   input  logic [mem_req_pkg::DATA_W-1:0]   wb_dat_i,
   input  logic                             wb_ack_i,
   output logic                             rsp_valid_o,
   output logic [mem_req_pkg::TAG_W-1:0]    rsp_tag_o,
   output logic [mem_req_pkg::DATA_W-1:0]   rsp_data_o
);
   import mem_req_pkg::*;

   logic                q_valid;
   mem_op_e             q_op;
   logic [ADDR_W-1:0]   q_addr;
   logic [DATA_W-1:0]   q_data;                   // only meaningful for write heads
   logic [TAG_W-1:0]    q_tag;
   logic                q_pop;

   req_queue u_req_queue (
      .clk     (clk),
      .rst_n   (rst_n),
      .valid_i (req_valid_i),
      .op_i    (req_op_i),
      .addr_i  (req_addr_i),
      .data_i  (req_data_i),
      .tag_i   (req_tag_i),
      .grant_o (req_grant_o),
      .valid_o (q_valid),
      .op_o    (q_op),
      .addr_o  (q_addr),
      .data_o  (q_data),
      .tag_o   (q_tag),
      .pop_i   (q_pop)
   );

   wb_issue u_wb_issue (
      .clk         (clk),
      .rst_n       (rst_n),
      .q_valid_i   (q_valid),
      .q_op_i      (q_op),
      .q_addr_i    (q_addr),
      .q_data_i    (q_data),
      .q_tag_i     (q_tag),
      .q_pop_o     (q_pop),
      .wb_cyc_o    (wb_cyc_o),
      .wb_stb_o    (wb_stb_o),
      .wb_we_o     (wb_we_o),
      .wb_adr_o    (wb_adr_o),
      .wb_dat_o    (wb_dat_o),
      .wb_dat_i    (wb_dat_i),
      .wb_ack_i    (wb_ack_i),
      .rsp_valid_o (rsp_valid_o),
      .rsp_tag_o   (rsp_tag_o),
      .rsp_data_o  (rsp_data_o)
   );

endmodule

// File: rtl/mem_req_pkg.sv
package mem_req_pkg;

   // header ring, one entry per request
   localparam int QUEUE_DEPTH = 12;

   // write payload ring, shared only by write entries
   localparam int DATA_DEPTH = 4;

   localparam int ADDR_W = 8;                     // word address
   localparam int DATA_W = 32;
   localparam int TAG_W = 3;                      // names the client read-entry slot

   localparam int QPTR_W = $clog2(QUEUE_DEPTH);
   localparam int DPTR_W = $clog2(DATA_DEPTH);

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } mem_op_e;

endpackage

// File: rtl/req_queue.sv
`timescale 1ns/100ps

module req_queue (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             valid_i,
   input  mem_req_pkg::mem_op_e             op_i,
   input  logic [mem_req_pkg::ADDR_W-1:0]   addr_i,
   input  logic [mem_req_pkg::DATA_W-1:0]   data_i,
   input  logic [mem_req_pkg::TAG_W-1:0]    tag_i,
   output logic                             grant_o,
   output logic                             valid_o,
   output mem_req_pkg::mem_op_e             op_o,
   output logic [mem_req_pkg::ADDR_W-1:0]   addr_o,
   output logic [mem_req_pkg::DATA_W-1:0]   data_o,
   output logic [mem_req_pkg::TAG_W-1:0]    tag_o,
   input  logic                             pop_i
);
   import mem_req_pkg::*;

   typedef enum logic [1:0] {
      ST_EMPTY,
      ST_MIDDLE,
      ST_FULL
   } queue_state_e;

   queue_state_e        state_q;
   queue_state_e        state_nxt;

   logic [QPTR_W-1:0]   hdr_wr_q;
   logic [QPTR_W-1:0]   hdr_wr_nxt;
   logic [QPTR_W-1:0]   hdr_rd_q;
   logic [QPTR_W-1:0]   hdr_rd_nxt;
   logic [DPTR_W-1:0]   dat_wr_q;
   logic [DPTR_W-1:0]   dat_wr_nxt;
   logic [DPTR_W-1:0]   dat_rd_q;
   logic [DPTR_W-1:0]   dat_rd_nxt;
   logic                pay_full_q;                // payload ring holds DATA_DEPTH writes
   logic                pay_full_nxt;

   logic                push;
   logic                pop;
   logic                push_wr;
   logic                pop_wr;
   logic                fill_hdr;
   logic                fill_pay;
   logic                drain_hdr;

   mem_op_e             hdr_op_mem   [QUEUE_DEPTH];
   logic [ADDR_W-1:0]   hdr_addr_mem [QUEUE_DEPTH];
   logic [TAG_W-1:0]    hdr_tag_mem  [QUEUE_DEPTH];
   logic [DATA_W-1:0]   pay_mem      [DATA_DEPTH];

   function automatic logic [QPTR_W-1:0] next_qptr(input logic [QPTR_W-1:0] ptr);
      if (ptr == QPTR_W'(QUEUE_DEPTH - 1)) begin
         return '0;
      end else begin
         return ptr + 1'b1;
      end
   endfunction

   function automatic logic [DPTR_W-1:0] next_dptr(input logic [DPTR_W-1:0] ptr);
      if (ptr == DPTR_W'(DATA_DEPTH - 1)) begin
         return '0;
      end else begin
         return ptr + 1'b1;
      end
   endfunction

   assign grant_o = (state_q != ST_FULL);
   assign valid_o = (state_q != ST_EMPTY);

   assign push    = valid_i && grant_o;
   assign pop     = pop_i && valid_o;
   assign push_wr = push && (op_i == OP_WRITE);   // payload side follows the incoming opcode
   assign pop_wr  = pop && (op_o == OP_WRITE);    // and the head opcode on the way out

   always_comb begin
      hdr_wr_nxt = push ? next_qptr(hdr_wr_q) : hdr_wr_q;
      hdr_rd_nxt = pop ? next_qptr(hdr_rd_q) : hdr_rd_q;
      dat_wr_nxt = push_wr ? next_dptr(dat_wr_q) : dat_wr_q;
      dat_rd_nxt = pop_wr ? next_dptr(dat_rd_q) : dat_rd_q;
   end

   // pointers meeting after a one-sided move means the ring just filled or drained
   assign fill_hdr     = push && !pop && (hdr_wr_nxt == hdr_rd_q);
   assign fill_pay     = push_wr && !pop_wr && (dat_wr_nxt == dat_rd_q);
   assign drain_hdr    = pop && !push && (hdr_rd_nxt == hdr_wr_q);
   assign pay_full_nxt = fill_pay || (pay_full_q && !pop_wr);

   always_comb begin
      state_nxt = state_q;
      case (state_q)
         ST_EMPTY: begin
            if (push) begin
               state_nxt = (fill_hdr || fill_pay) ? ST_FULL : ST_MIDDLE;
            end
         end
         ST_MIDDLE: begin
            if (drain_hdr) begin
               state_nxt = ST_EMPTY;
            end else if (fill_hdr || fill_pay) begin
               state_nxt = ST_FULL;
            end
         end
         ST_FULL: begin
            if (pop && !pay_full_nxt) begin       // a read leaving frees nothing on a full payload ring
               state_nxt = ST_MIDDLE;
            end
         end
         default: begin
            state_nxt = ST_EMPTY;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q    <= ST_EMPTY;
         hdr_wr_q   <= '0;
         hdr_rd_q   <= '0;
         dat_wr_q   <= '0;
         dat_rd_q   <= '0;
         pay_full_q <= 1'b0;
      end else begin
         state_q    <= state_nxt;
         hdr_wr_q   <= hdr_wr_nxt;
         hdr_rd_q   <= hdr_rd_nxt;
         dat_wr_q   <= dat_wr_nxt;
         dat_rd_q   <= dat_rd_nxt;
         pay_full_q <= pay_full_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         hdr_op_mem[hdr_wr_q]   <= op_i;
         hdr_addr_mem[hdr_wr_q] <= addr_i;
         hdr_tag_mem[hdr_wr_q]  <= tag_i;
      end
      if (push_wr) begin
         pay_mem[dat_wr_q] <= data_i;            // reads take no payload slot
      end
   end

   assign op_o   = hdr_op_mem[hdr_rd_q];
   assign addr_o = hdr_addr_mem[hdr_rd_q];
   assign tag_o  = hdr_tag_mem[hdr_rd_q];
   assign data_o = pay_mem[dat_rd_q];

   // a read head may see its payload slot rewritten by a newer write, so data is
   // only held for write heads
   property p_head_stable;
      @(posedge clk) disable iff (!rst_n)
         valid_o && !pop_i |=> valid_o && $stable(op_o) && $stable(addr_o)
            && $stable(tag_o) && ((op_o != OP_WRITE) || $stable(data_o));
   endproperty

   a_head_stable: assert property (p_head_stable);

   // a ring that really is full must refuse every push
   property p_no_push_when_full;
      @(posedge clk) disable iff (!rst_n)
         pay_full_q || (valid_o && (hdr_wr_q == hdr_rd_q))
            |=> $stable(hdr_wr_q) && $stable(dat_wr_q);
   endproperty

   a_no_push_when_full: assert property (p_no_push_when_full);

endmodule

// File: rtl/wb_issue.sv
`timescale 1ns/100ps

module wb_issue (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             q_valid_i,
   input  mem_req_pkg::mem_op_e             q_op_i,
   input  logic [mem_req_pkg::ADDR_W-1:0]   q_addr_i,
   input  logic [mem_req_pkg::DATA_W-1:0]   q_data_i,
   input  logic [mem_req_pkg::TAG_W-1:0]    q_tag_i,
   output logic                             q_pop_o,
   output logic                             wb_cyc_o,
   output logic                             wb_stb_o,
   output logic                             wb_we_o,
   output logic [mem_req_pkg::ADDR_W-1:0]   wb_adr_o,
   output logic [mem_req_pkg::DATA_W-1:0]   wb_dat_o,
   input  logic [mem_req_pkg::DATA_W-1:0]   wb_dat_i,
   input  logic                             wb_ack_i,
   output logic                             rsp_valid_o,
   output logic [mem_req_pkg::TAG_W-1:0]    rsp_tag_o,
   output logic [mem_req_pkg::DATA_W-1:0]   rsp_data_o
);
   import mem_req_pkg::*;

   typedef enum logic {
      ST_IDLE,
      ST_BUS
   } issue_state_e;

   issue_state_e   state_q;
   logic           bus_done;
   logic           read_done;

   assign bus_done  = (state_q == ST_BUS) && wb_ack_i;
   assign read_done = bus_done && (q_op_i == OP_READ);

   assign q_pop_o = bus_done;                     // the entry leaves on the ack edge

   // the queue head stays put until popped, so the bus can take it directly
   assign wb_we_o  = (q_op_i == OP_WRITE);
   assign wb_adr_o = q_addr_i;
   assign wb_dat_o = q_data_i;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q  <= ST_IDLE;
         wb_cyc_o <= 1'b0;
         wb_stb_o <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (q_valid_i) begin
                  state_q  <= ST_BUS;
                  wb_cyc_o <= 1'b1;
                  wb_stb_o <= 1'b1;
               end
            end
            ST_BUS: begin
               if (wb_ack_i) begin
                  state_q  <= ST_IDLE;
                  wb_cyc_o <= 1'b0;
                  wb_stb_o <= 1'b0;
               end
            end
            default: begin
               state_q  <= ST_IDLE;
               wb_cyc_o <= 1'b0;
               wb_stb_o <= 1'b0;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp_valid_o <= 1'b0;
      end else begin
         rsp_valid_o <= read_done;                // one cycle, writes retire silently
      end
   end

   always_ff @(posedge clk) begin
      if (read_done) begin
         rsp_tag_o  <= q_tag_i;
         rsp_data_o <= wb_dat_i;
      end
   end

   // the strobe only runs on a live queue head
   a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
      wb_stb_o |-> wb_cyc_o && q_valid_i);

   // holds only as long as the queue keeps its head stable
   property p_adr_hold;
      @(posedge clk) disable iff (!rst_n)
         wb_cyc_o && !wb_ack_i |=> wb_cyc_o && $stable(wb_adr_o) && $stable(wb_we_o);
   endproperty

   a_adr_hold: assert property (p_adr_hold);

endmodule

// File: test/tb_mem_req_path.sv
`timescale 1ns/100ps

module tb_mem_req_path;
   import mem_req_pkg::*;

   localparam int NUM_ROWS       = 36;
   localparam int TIMEOUT_CYCLES = NUM_ROWS * (8 + QUEUE_DEPTH) + 100;

   logic                clk;
   logic                rst_n;
   logic                req_valid;
   mem_op_e             req_op;
   logic [ADDR_W-1:0]   req_addr;
   logic [DATA_W-1:0]   req_data;
   logic [TAG_W-1:0]    req_tag;
   logic                req_grant;
   logic                wb_cyc;
   logic                wb_stb;
   logic                wb_we;
   logic [ADDR_W-1:0]   wb_adr;
   logic [DATA_W-1:0]   wb_dat_w;
   logic [DATA_W-1:0]   wb_dat_r;
   logic                wb_ack;
   logic                rsp_valid;
   logic [TAG_W-1:0]    rsp_tag;
   logic [DATA_W-1:0]   rsp_data;
   logic [2:0]          ack_delay;

   mem_op_e             tbl_op   [NUM_ROWS];
   logic [ADDR_W-1:0]   tbl_addr [NUM_ROWS];
   logic [DATA_W-1:0]   tbl_data [NUM_ROWS];
   logic                tbl_slow [NUM_ROWS];   // slow rows get the longest ack delay

   logic [DATA_W-1:0]   shadow [2**ADDR_W];
   mem_op_e             exp_op_q    [$];
   logic [ADDR_W-1:0]   exp_addr_q  [$];
   logic [DATA_W-1:0]   exp_wdata_q [$];
   logic [2:0]          exp_delay_q [$];
   logic [TAG_W-1:0]    exp_tag_q   [$];
   logic [DATA_W-1:0]   exp_rdata_q [$];

   logic [31:0]         lcg_state;
   int                  q_entries;
   int                  q_writes;
   int                  cycle_cnt;
   logic                saw_pay_full;
   logic                saw_hdr_full;

   mem_req_path u_mem_req_path (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid_i (req_valid),
      .req_op_i    (req_op),
      .req_addr_i  (req_addr),
      .req_data_i  (req_data),
      .req_tag_i   (req_tag),
      .req_grant_o (req_grant),
      .wb_cyc_o    (wb_cyc),
      .wb_stb_o    (wb_stb),
      .wb_we_o     (wb_we),
      .wb_adr_o    (wb_adr),
      .wb_dat_o    (wb_dat_w),
      .wb_dat_i    (wb_dat_r),
      .wb_ack_i    (wb_ack),
      .rsp_valid_o (rsp_valid),
      .rsp_tag_o   (rsp_tag),
      .rsp_data_o  (rsp_data)
   );

   wb_mem_model u_wb_mem_model (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_w),
      .wb_dat_o (wb_dat_r),
      .wb_ack_o (wb_ack),
      .delay_i  (ack_delay)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic end_with_failure();
      $display("sim failed");
      $fatal(1, "run stopped on the first failure");
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
         end_with_failure();
      end
   endtask

   task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                             input logic [ADDR_W-1:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
         end_with_failure();
      end
   endtask

   task automatic check_tag(input string name, input logic [TAG_W-1:0] got,
                            input logic [TAG_W-1:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
         end_with_failure();
      end
   endtask

   task automatic check_op(input string name, input mem_op_e got, input mem_op_e exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s expected %s, got %s", $time, name, exp.name(),
                  got.name());
         end_with_failure();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, got);
         end_with_failure();
      end
   endtask

   task automatic set_row(input int idx, input mem_op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, input logic slow);
      tbl_op[idx]   = op;
      tbl_addr[idx] = addr;
      tbl_data[idx] = data;
      tbl_slow[idx] = slow;
   endtask

   task automatic load_table();
      set_row(0, OP_WRITE, 8'h10, 32'h1111_1111, 1'b0);
      set_row(1, OP_WRITE, 8'h20, 32'h2222_2222, 1'b0);
      set_row(2, OP_READ,  8'h10, 32'hBAD0_0010, 1'b0);   // read data column is ignored
      set_row(3, OP_READ,  8'h20, 32'hBAD0_0020, 1'b0);
      set_row(4, OP_READ,  8'h30, 32'hBAD0_0030, 1'b0);   // never written, reads zero
      set_row(5, OP_WRITE, 8'h10, 32'h3333_3333, 1'b0);
      set_row(6, OP_READ,  8'h10, 32'hBAD0_0010, 1'b0);
      for (int k = 0; k < 6; k++) begin                  // slow writes fill the payload ring
         set_row(7 + k, OP_WRITE, 8'h40 + k, 32'hC0DE_0040 + k, 1'b1);
      end
      for (int k = 0; k < 14; k++) begin                 // slow reads fill the header ring
         set_row(13 + k, OP_READ, 8'h40 + (k % 6), 32'hBAD1_0000 + k, 1'b1);
      end
      set_row(27, OP_READ, 8'h10, 32'hBAD2_0010, 1'b0);
      set_row(28, OP_READ, 8'h20, 32'hBAD2_0020, 1'b0);
      set_row(29, OP_READ, 8'h30, 32'hBAD2_0030, 1'b0);
      for (int k = 0; k < 6; k++) begin
         set_row(30 + k, OP_READ, 8'h40 + k, 32'hBAD2_0040 + k, 1'b0);
      end
   endtask

   // builds the expected bus cycle and, for reads, the expected response
   task automatic record_push(input int idx);
      logic [2:0] delay;
      if (tbl_slow[idx]) begin
         delay = 3'd7;
      end else begin
         lcg_state = lcg_next(lcg_state);
         delay     = lcg_state[30:28];
      end
      exp_op_q.push_back(tbl_op[idx]);
      exp_addr_q.push_back(tbl_addr[idx]);
      exp_wdata_q.push_back(tbl_data[idx]);
      exp_delay_q.push_back(delay);
      if (tbl_op[idx] == OP_WRITE) begin
         shadow[tbl_addr[idx]] = tbl_data[idx];
      end else begin
         exp_tag_q.push_back(TAG_W'(idx));
         exp_rdata_q.push_back(shadow[tbl_addr[idx]]);
      end
   endtask

   // ack delay of the head request, taken by the model in the first cycle of each transfer
   always @(posedge clk) begin
      #10;
      ack_delay = (exp_delay_q.size() != 0) ? exp_delay_q[0] : 3'd0;
   end

   always @(negedge clk) begin : bus_monitor
      mem_op_e done_op;
      if (rst_n) begin
         check_flag("req_grant_o", req_grant,
                    !((q_entries == QUEUE_DEPTH) || (q_writes == DATA_DEPTH)));
         if (q_writes == DATA_DEPTH) begin
            saw_pay_full = 1'b1;
         end
         if ((q_entries == QUEUE_DEPTH) && (q_writes < DATA_DEPTH)) begin
            saw_hdr_full = 1'b1;
         end
         if (wb_cyc && wb_stb && wb_ack) begin
            if (exp_op_q.size() == 0) begin
               $display("bus cycle at %0t ns with no request pushed for it", $time);
               end_with_failure();
            end
            done_op = exp_op_q.pop_front();
            check_op("wb_we_o", wb_we ? OP_WRITE : OP_READ, done_op);
            check_addr("wb_adr_o", wb_adr, exp_addr_q.pop_front());
            if (done_op == OP_WRITE) begin
               check_word("wb_dat_o", wb_dat_w, exp_wdata_q[0]);
               q_writes--;
            end
            void'(exp_wdata_q.pop_front());
            void'(exp_delay_q.pop_front());
            q_entries--;
         end
         if (req_valid && req_grant) begin         // accepted on the coming edge
            q_entries++;
            if (req_op == OP_WRITE) begin
               q_writes++;
            end
         end
         if (rsp_valid) begin
            if (exp_tag_q.size() == 0) begin
               $display("read response at %0t ns with no read outstanding", $time);
               end_with_failure();
            end
            check_tag("rsp_tag_o", rsp_tag, exp_tag_q.pop_front());
            check_word("rsp_data_o", rsp_data, exp_rdata_q.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, requests or responses still outstanding",
                  cycle_cnt);
         end_with_failure();
      end
   end

   initial begin
      rst_n        = 1'b0;
      req_valid    = 1'b0;
      req_op       = OP_READ;
      req_addr     = '0;
      req_data     = '0;
      req_tag      = '0;
      ack_delay    = 3'd0;
      lcg_state    = 32'h7188;
      q_entries    = 0;
      q_writes     = 0;
      cycle_cnt    = 0;
      saw_pay_full = 1'b0;
      saw_hdr_full = 1'b0;
      for (int a = 0; a < 2**ADDR_W; a++) begin
         shadow[a] = '0;
      end
      load_table();

      repeat (10) @(posedge clk);
      #10;
      rst_n = 1'b1;
      @(posedge clk);
      #10;
      check_flag("req_grant_o", req_grant, 1'b1);
      check_flag("wb_cyc_o", wb_cyc, 1'b0);
      check_flag("wb_stb_o", wb_stb, 1'b0);
      check_flag("rsp_valid_o", rsp_valid, 1'b0);

      for (int i = 0; i < NUM_ROWS; i++) begin
         req_valid = 1'b1;
         req_op    = tbl_op[i];
         req_addr  = tbl_addr[i];
         req_data  = tbl_data[i];
         req_tag   = TAG_W'(i);
         while (!req_grant) begin                  // hold the row until granted
            @(posedge clk);
            #10;
         end
         record_push(i);
         @(posedge clk);
         #10;
      end
      req_valid = 1'b0;

      while ((exp_op_q.size() != 0) || (exp_tag_q.size() != 0)) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk);

      if (saw_pay_full && saw_hdr_full) begin
         $display("sim passed");
         $finish;
      end else begin
         $display("queue drained without reaching both back-pressure conditions");
         $display("payload ring full seen %0b, header ring full seen %0b",
                  saw_pay_full, saw_hdr_full);
         end_with_failure();
      end
   end

endmodule

// File: test/wb_mem_model.sv
`timescale 1ns/100ps

module wb_mem_model (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             wb_cyc_i,
   input  logic                             wb_stb_i,
   input  logic                             wb_we_i,
   input  logic [mem_req_pkg::ADDR_W-1:0]   wb_adr_i,
   input  logic [mem_req_pkg::DATA_W-1:0]   wb_dat_i,
   output logic [mem_req_pkg::DATA_W-1:0]   wb_dat_o,
   output logic                             wb_ack_o,
   input  logic [2:0]                       delay_i
);
   import mem_req_pkg::*;

   logic [DATA_W-1:0]   mem [2**ADDR_W];
   logic                started_q;                // delay_i already taken for this cycle
   logic [2:0]          wait_q;
   logic                req;

   assign req      = wb_cyc_i && wb_stb_i;
   assign wb_ack_o = req && (started_q ? (wait_q == 3'd0) : (delay_i == 3'd0));
   assign wb_dat_o = mem[wb_adr_i];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         started_q <= 1'b0;
         wait_q    <= '0;
         for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] <= '0;
         end
      end else begin
         if (wb_ack_o) begin
            started_q <= 1'b0;
            if (wb_we_i) begin
               mem[wb_adr_i] <= wb_dat_i;        // writes land on the ack edge
            end
         end else if (req) begin
            started_q <= 1'b1;
            wait_q    <= started_q ? (wait_q - 3'd1) : (delay_i - 3'd1);
         end
      end
   end

endmodule
